/* Bender.yml */
package:
  name: lsu

sources:
  - source/lsu_pkg.sv
  - source/lsu_access_ctrl.sv
  - source/lsu_data_mem.sv
  - source/lsu_io_regs.sv
  - source/lsu_load_align.sv
  - source/lsu_top.sv
  - target: test
    files:
      - test/lsu_tb.sv

/* list.f */
source/lsu_pkg.sv
source/lsu_access_ctrl.sv
source/lsu_data_mem.sv
source/lsu_io_regs.sv
source/lsu_load_align.sv
source/lsu_top.sv
test/lsu_tb.sv

/* source/lsu_access_ctrl.sv */
/* region decode, store lane placement and load context register
   store ops without i_lsu_wren are treated as loads that return zero */
`timescale 1ns/1ps
`default_nettype none

module lsu_access_ctrl import lsu_pkg::*; (
  input  wire                    i_clk,
  input  wire                    i_reset,
  input  word_t                  i_lsu_addr,
  input  lsu_op_e                i_lsu_op,
  input  wire                    i_lsu_wren,
  input  word_t                  i_st_data,
  output byte_en_t               o_mem_be,
  output byte_en_t               o_out_be,
  output out_idx_t               o_out_idx,
  output logic [MEM_ADDR_W-1:0]  o_word_idx,
  output word_t                  o_st_lanes,
  output region_e                o_ld_region,
  output lsu_op_e                o_ld_op,
  output logic [1:0]             o_ld_offset
);

  region_e  region;
  logic     is_store_op;
  logic     do_store;
  byte_en_t lane_be;
  logic [1:0] offset;

  assign offset      = i_lsu_addr[1:0];
  assign is_store_op = i_lsu_op inside {SB, SH, SW};
  assign do_store    = i_lsu_wren && is_store_op;

  always_comb begin
    if (i_lsu_addr[31:MEM_ADDR_W+2] == '0) begin
      region = REGION_MEM;
    end else if (i_lsu_addr[31:16] == OUT_BASE[31:16] &&
                 i_lsu_addr[15:OUT_STRIDE_LSB] < OUT_REGS) begin
      region = REGION_OUT;
    end else if (i_lsu_addr[31:16] == SW_ADDR[31:16]) begin
      region = REGION_SW;
    end else begin
      region = REGION_NONE;
    end
  end

  // lanes touched by the store, offset bit 0 ignored for halfwords
  always_comb begin
    case (i_lsu_op)
      SB:      lane_be = byte_en_t'(4'b0001 << offset);
      SH:      lane_be = offset[1] ? 4'b1100 : 4'b0011;
      SW:      lane_be = 4'b1111;
      default: lane_be = 4'b0000;
    endcase
  end

  // replicated so every enabled lane sees the right source bytes
  always_comb begin
    case (i_lsu_op)
      SB:      o_st_lanes = {4{i_st_data[7:0]}};
      SH:      o_st_lanes = {2{i_st_data[15:0]}};
      default: o_st_lanes = i_st_data;
    endcase
  end

  assign o_mem_be   = (do_store && region == REGION_MEM) ? lane_be : '0;
  assign o_out_be   = (do_store && region == REGION_OUT) ? lane_be : '0;
  assign o_out_idx  = i_lsu_addr[OUT_STRIDE_LSB +: 2];
  assign o_word_idx = i_lsu_addr[MEM_ADDR_W+1:2];

  always_ff @(posedge i_clk) begin
    if (i_reset || is_store_op) begin
      o_ld_region <= REGION_NONE; // store slot reads back as zero
    end else begin
      o_ld_region <= region;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ld_op     <= i_lsu_op;
    o_ld_offset <= offset;
  end

endmodule

`default_nettype wire

/* source/lsu_data_mem.sv */
/* 2 KB word memory, byte write enables, one-cycle registered read
   no reset, contents are undefined until written */
`timescale 1ns/1ps
`default_nettype none

module lsu_data_mem import lsu_pkg::*; (
  input  wire                   i_clk,
  input  wire [MEM_ADDR_W-1:0]  i_word_idx,
  input  byte_en_t              i_be,
  input  word_t                 i_wdata,
  output word_t                 o_rdata
);

  word_t mem [MEM_WORDS];

  // each lane with its enable set takes the new byte
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < 4; b++) begin
      if (i_be[b]) begin
        mem[i_word_idx][8*b +: 8] <= i_wdata[8*b +: 8];
      end
    end
  end

  // old word on a write cycle where the result is discarded anyway
  always_ff @(posedge i_clk) begin
    o_rdata <= mem[i_word_idx];
  end

endmodule

`default_nettype wire

/* source/lsu_io_regs.sv */
/* output registers for LEDs and digits plus switch sampling register
   digit fields are the low 7 bits of each byte, bit 7 of each byte is kept but unused */
`timescale 1ns/1ps
`default_nettype none

module lsu_io_regs import lsu_pkg::*; (
  input  wire      i_clk,
  input  wire      i_reset,
  input  out_idx_t i_out_idx,
  input  byte_en_t i_be,
  input  word_t    i_wdata,
  input  word_t    i_io_sw,
  output word_t    o_out_rdata,
  output word_t    o_sw_rdata,
  output word_t    o_io_ledr,
  output word_t    o_io_ledg,
  output seg_t     o_io_hex0,
  output seg_t     o_io_hex1,
  output seg_t     o_io_hex2,
  output seg_t     o_io_hex3,
  output seg_t     o_io_hex4,
  output seg_t     o_io_hex5,
  output seg_t     o_io_hex6,
  output seg_t     o_io_hex7
);

  word_t out_regs [OUT_REGS];
  word_t sw_q;

  // byte writes, enables already gated to this region
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int r = 0; r < OUT_REGS; r++) begin
        out_regs[r] <= '0;
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (i_be[b]) begin
          out_regs[i_out_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_out_rdata <= out_regs[i_out_idx]; // registered readback
  end

  // sampled every edge, a load gets the value from the edge ending its cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      sw_q <= '0;
    end else begin
      sw_q <= i_io_sw;
    end
  end

  assign o_sw_rdata = sw_q;

  assign o_io_ledr = out_regs[OUT_LEDR];
  assign o_io_ledg = out_regs[OUT_LEDG];

  assign o_io_hex0 = out_regs[OUT_HEX_LO][6:0];
  assign o_io_hex1 = out_regs[OUT_HEX_LO][14:8];
  assign o_io_hex2 = out_regs[OUT_HEX_LO][22:16];
  assign o_io_hex3 = out_regs[OUT_HEX_LO][30:24];
  assign o_io_hex4 = out_regs[OUT_HEX_HI][6:0];
  assign o_io_hex5 = out_regs[OUT_HEX_HI][14:8];
  assign o_io_hex6 = out_regs[OUT_HEX_HI][22:16];
  assign o_io_hex7 = out_regs[OUT_HEX_HI][30:24];

endmodule

`default_nettype wire

/* source/lsu_load_align.sv */
/* picks the read word by region, extracts the addressed lane and extends it
   purely combinational from the registered load context */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  region_e    i_region,
  input  lsu_op_e    i_op,
  input  wire [1:0]  i_offset,
  input  word_t      i_mem_rdata,
  input  word_t      i_out_rdata,
  input  word_t      i_sw_rdata,
  output word_t      o_ld_data
);

  word_t       src;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  always_comb begin
    case (i_region)
      REGION_MEM: src = i_mem_rdata;
      REGION_OUT: src = i_out_rdata;
      REGION_SW:  src = i_sw_rdata;
      default:    src = '0; // unmapped or store slot
    endcase
  end

  assign byte_sel = src[8*i_offset +: 8];
  assign half_sel = i_offset[1] ? src[31:16] : src[15:0]; // offset bit 0 ignored

  always_comb begin
    case (i_op)
      LB:      o_ld_data = {{24{byte_sel[7]}}, byte_sel};
      LBU:     o_ld_data = {24'd0, byte_sel};
      LH:      o_ld_data = {{16{half_sel[15]}}, half_sel};
      LHU:     o_ld_data = {16'd0, half_sel};
      LW:      o_ld_data = src;
      default: o_ld_data = '0; // store codes never carry a load
    endcase
  end

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
/* shared address map, access codes and types for the load/store unit
   data memory is 2 KB at address 0, contents undefined after reset */
`default_nettype none

package lsu_pkg;

  typedef logic [31:0] word_t;    // bus word, address or data
  typedef logic [3:0]  byte_en_t; // one enable per byte lane
  typedef logic [6:0]  seg_t;     // segments of one digit
  typedef logic [1:0]  out_idx_t; // output register index

  // access type codes as carried on i_lsu_op
  typedef enum logic [2:0] {
    SB  = 3'd0,
    SH  = 3'd1,
    SW  = 3'd2,
    LB  = 3'd3,
    LH  = 3'd4,
    LW  = 3'd5,
    LBU = 3'd6,
    LHU = 3'd7
  } lsu_op_e;

  // target of one access
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_MEM  = 2'd1,
    REGION_OUT  = 2'd2,
    REGION_SW   = 2'd3
  } region_e;

  // data memory
  localparam int MEM_BYTES  = 2048;
  localparam int MEM_WORDS  = MEM_BYTES / 4;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS); // word index bits

  // output registers, one per 4 KB page starting at OUT_BASE
  localparam word_t OUT_BASE       = 32'h1000_0000;
  localparam int    OUT_STRIDE_LSB = 12; // lowest bit of the register index
  localparam int    OUT_REGS       = 4;

  localparam out_idx_t OUT_LEDR   = 2'd0;
  localparam out_idx_t OUT_LEDG   = 2'd1;
  localparam out_idx_t OUT_HEX_LO = 2'd2; // digits 0 to 3
  localparam out_idx_t OUT_HEX_HI = 2'd3; // digits 4 to 7

  // switch input, whole 64 KB page decodes to the one register
  localparam word_t SW_ADDR = 32'h1001_0000;

endpackage

`default_nettype wire

/* source/lsu_top.sv */
/* load/store unit on a fixed one-cycle synchronous bus, no back-pressure
   o_ld_data is zero in the cycle after a store and for unmapped loads */
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire     i_clk,
  input  wire     i_reset,
  input  word_t   i_lsu_addr,
  input  lsu_op_e i_lsu_op,
  input  wire     i_lsu_wren,
  input  word_t   i_st_data,
  output word_t   o_ld_data,
  input  word_t   i_io_sw,
  output word_t   o_io_ledr,
  output word_t   o_io_ledg,
  output seg_t    o_io_hex0,
  output seg_t    o_io_hex1,
  output seg_t    o_io_hex2,
  output seg_t    o_io_hex3,
  output seg_t    o_io_hex4,
  output seg_t    o_io_hex5,
  output seg_t    o_io_hex6,
  output seg_t    o_io_hex7
);

  byte_en_t              mem_be;
  byte_en_t              out_be;
  out_idx_t              out_idx;
  logic [MEM_ADDR_W-1:0] word_idx;
  word_t                 st_lanes;
  region_e               ld_region;
  lsu_op_e               ld_op;
  logic [1:0]            ld_offset;
  word_t                 mem_rdata;
  word_t                 out_rdata;
  word_t                 sw_rdata;

  lsu_access_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_lsu_addr  (i_lsu_addr),
    .i_lsu_op    (i_lsu_op),
    .i_lsu_wren  (i_lsu_wren),
    .i_st_data   (i_st_data),
    .o_mem_be    (mem_be),
    .o_out_be    (out_be),
    .o_out_idx   (out_idx),
    .o_word_idx  (word_idx),
    .o_st_lanes  (st_lanes),
    .o_ld_region (ld_region),
    .o_ld_op     (ld_op),
    .o_ld_offset (ld_offset)
  );

  lsu_data_mem u_mem (
    .i_clk      (i_clk),
    .i_word_idx (word_idx),
    .i_be       (mem_be),
    .i_wdata    (st_lanes),
    .o_rdata    (mem_rdata)
  );

  lsu_io_regs u_io (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_out_idx   (out_idx),
    .i_be        (out_be),
    .i_wdata     (st_lanes),
    .i_io_sw     (i_io_sw),
    .o_out_rdata (out_rdata),
    .o_sw_rdata  (sw_rdata),
    .o_io_ledr   (o_io_ledr),
    .o_io_ledg   (o_io_ledg),
    .o_io_hex0   (o_io_hex0),
    .o_io_hex1   (o_io_hex1),
    .o_io_hex2   (o_io_hex2),
    .o_io_hex3   (o_io_hex3),
    .o_io_hex4   (o_io_hex4),
    .o_io_hex5   (o_io_hex5),
    .o_io_hex6   (o_io_hex6),
    .o_io_hex7   (o_io_hex7)
  );

  lsu_load_align u_align (
    .i_region    (ld_region),
    .i_op        (ld_op),
    .i_offset    (ld_offset),
    .i_mem_rdata (mem_rdata),
    .i_out_rdata (out_rdata),
    .i_sw_rdata  (sw_rdata),
    .o_ld_data   (o_ld_data)
  );

endmodule

`default_nettype wire

/* test/lsu_tb.sv */
/* random load/store traffic checked against a model of memory, output regs and switches
   memory words are written before they are read since contents are undefined after reset */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  localparam int SEED       = 73047;
  localparam int MAX_CYCLES = 4000; // whole run is about 2800 cycles

  logic    i_clk;
  logic    i_reset;
  word_t   i_lsu_addr;
  lsu_op_e i_lsu_op;
  logic    i_lsu_wren;
  word_t   i_st_data;
  word_t   i_io_sw;
  word_t   o_ld_data;
  word_t   o_io_ledr;
  word_t   o_io_ledg;
  seg_t    o_io_hex [8];

  word_t rng_state;
  word_t mem_model [MEM_WORDS];
  word_t out_model [OUT_REGS];
  word_t sw_val;     // value driven on i_io_sw
  word_t pend_exp;
  string pend_name;

  lsu_top DUT (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_lsu_addr (i_lsu_addr),
    .i_lsu_op   (i_lsu_op),
    .i_lsu_wren (i_lsu_wren),
    .i_st_data  (i_st_data),
    .o_ld_data  (o_ld_data),
    .i_io_sw    (i_io_sw),
    .o_io_ledr  (o_io_ledr),
    .o_io_ledg  (o_io_ledg),
    .o_io_hex0  (o_io_hex[0]),
    .o_io_hex1  (o_io_hex[1]),
    .o_io_hex2  (o_io_hex[2]),
    .o_io_hex3  (o_io_hex[3]),
    .o_io_hex4  (o_io_hex[4]),
    .o_io_hex5  (o_io_hex[5]),
    .o_io_hex6  (o_io_hex[6]),
    .o_io_hex7  (o_io_hex[7])
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // address map as seen by software
  function automatic region_e region_of(input word_t addr);
    if (addr[31:11] == '0) begin
      return REGION_MEM;
    end else if (addr[31:16] == OUT_BASE[31:16] && addr[15:12] < OUT_REGS) begin
      return REGION_OUT;
    end else if (addr[31:16] == SW_ADDR[31:16]) begin
      return REGION_SW;
    end else begin
      return REGION_NONE;
    end
  endfunction

  function automatic word_t model_load(input word_t addr, input lsu_op_e op);
    word_t       src;
    logic [7:0]  b;
    logic [15:0] h;
    case (region_of(addr))
      REGION_MEM: src = mem_model[addr[10:2]];
      REGION_OUT: src = out_model[addr[13:12]];
      REGION_SW:  src = sw_val;
      default:    src = '0;
    endcase
    b = src[8*addr[1:0] +: 8];
    h = addr[1] ? src[31:16] : src[15:0];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'd0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'd0, h};
      LW:      return src;
      default: return '0; // store slot reads back as zero
    endcase
  endfunction

  task automatic model_store(input word_t addr, input lsu_op_e op, input word_t data);
    word_t   w;
    region_e rg;
    rg = region_of(addr);
    if (rg == REGION_MEM || rg == REGION_OUT) begin
      w = (rg == REGION_MEM) ? mem_model[addr[10:2]] : out_model[addr[13:12]];
      case (op)
        SB: w[8*addr[1:0] +: 8] = data[7:0];
        SH: begin
          if (addr[1]) w[31:16] = data[15:0];
          else w[15:0] = data[15:0];
        end
        SW: w = data;
        default: ; // loads change nothing
      endcase
      if (rg == REGION_MEM) mem_model[addr[10:2]] = w;
      else out_model[addr[13:12]] = w;
    end
  endtask

  // output page 4..15 or anything with bit 31 set
  function automatic word_t unmapped_addr(input word_t r);
    logic [3:0] page;
    page = 4'd4 + r[7:4] % 4'd12;
    if (r[0]) return {OUT_BASE[31:16], page, r[19:8]};
    else return {1'b1, r[30:0]};
  endfunction

  task automatic fail_and_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      fail_and_stop($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_seg(input string name, input seg_t exp, input seg_t act);
    if (act !== exp) begin
      fail_and_stop($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_board(input string name);
    check_word({name, " ledr"}, out_model[OUT_LEDR], o_io_ledr);
    check_word({name, " ledg"}, out_model[OUT_LEDG], o_io_ledg);
    for (int d = 0; d < 8; d++) begin
      check_seg($sformatf("%s hex%0d", name, d),
                out_model[OUT_HEX_LO + d/4][8*(d%4) +: 7], o_io_hex[d]);
    end
  endtask

  // one access per cycle with the previous result checked mid-cycle
  task automatic step(input string name, input word_t addr, input lsu_op_e op,
                      input logic wren, input word_t data);
    @(posedge i_clk);
    i_lsu_addr <= addr;
    i_lsu_op   <= op;
    i_lsu_wren <= wren;
    i_st_data  <= data;
    i_io_sw    <= sw_val;
    @(negedge i_clk);
    check_word(pend_name, pend_exp, o_ld_data);
    check_board(name);
    pend_name  = $sformatf("%s op %0d addr %h", name, op, addr);
    pend_exp   = model_load(addr, op);
    if (wren) model_store(addr, op, data); // non-store ops are ignored
  endtask

  initial begin
    int c;
    for (c = 0; c < MAX_CYCLES; c++) @(posedge i_clk);
    fail_and_stop($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
  end

  initial begin
    int      n;
    word_t   r;
    lsu_op_e op;
    rng_state  = SEED;
    sw_val     = '0;
    pend_exp   = '0;
    pend_name  = "";
    i_reset    = 1'b1;
    i_lsu_addr = 32'hFFFF_FFF0; // unmapped so the first result is known
    i_lsu_op   = LW;
    i_lsu_wren = 1'b0;
    i_st_data  = '0;
    i_io_sw    = '0;
    foreach (out_model[i]) out_model[i] = '0;
    for (n = 0; n < 2; n++) @(posedge i_clk);
    i_reset <= 1'b0;
    @(negedge i_clk);
    check_word("reset ld_data", '0, o_ld_data);
    check_board("reset");
    pend_name  = "idle after reset";

    for (n = 0; n < MEM_WORDS; n++) step("mem init", word_t'(n*4), SW, 1'b1, next_rand());
    for (n = 0; n < 400; n++) begin
      r  = next_rand();
      op = r[31] ? SW : LW;
      step("mem word", {21'd0, r[10:2], 2'b00}, op, 1'b1, next_rand());
    end
    for (n = 0; n < 600; n++) begin
      r = next_rand();
      step("mem part", {21'd0, r[10:0]}, lsu_op_e'(r[31:29]), r[28:27] != 2'b00, next_rand());
    end
    for (n = 0; n < 300; n++) begin
      r = next_rand();
      step("out regs", {OUT_BASE[31:16], 2'b00, r[13:0]}, lsu_op_e'(r[31:29]), 1'b1,
           next_rand());
    end
    for (n = 0; n < 120; n++) begin
      if (n % 2 == 0) sw_val = next_rand(); // held for two cycles
      r = next_rand();
      case (r[31:30])
        2'd0:    op = LW;
        2'd1:    op = LBU;
        2'd2:    op = LH;
        default: op = SW;
      endcase
      step("switch", {SW_ADDR[31:16], r[15:0]}, op, 1'b1, next_rand());
    end
    for (n = 0; n < 200; n++) begin
      r = next_rand();
      step("unmapped", unmapped_addr(r), lsu_op_e'(r[10:8]), r[11], next_rand());
    end
    for (n = 0; n < 100; n++) begin
      r = next_rand();
      step("no wren", {21'd0, r[10:0]}, lsu_op_e'(r[31:30] % 2'd3), 1'b0, next_rand());
    end
    for (n = 0; n < MEM_WORDS; n++) step("mem sweep", word_t'(n*4), LW, 1'b0, '0);
    for (n = 0; n < OUT_REGS; n++) begin
      step("out sweep", OUT_BASE | word_t'(n << OUT_STRIDE_LSB), LW, 1'b0, '0);
    end
    step("flush", 32'hFFFF_FFF0, LW, 1'b0, '0);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
